// ==== clock_pkg.sv ====
package clock_pkg;

    typedef logic [4:0] hour_t;       // 0..23
    typedef logic [5:0] unit_t;       // minute or second, 0..59
    typedef logic [3:0] digit_t;      // 0..9, 10 is the dash
    typedef logic [7:0] seg_t;        // bit 7 = a ... bit 1 = g
    typedef logic [7:0] digit_sel_t;  // bit 7 = leftmost digit

    typedef enum logic [2:0] {
        cmd_none  = 3'd0,
        cmd_mode  = 3'd1,
        cmd_down  = 3'd2,
        cmd_field = 3'd3,
        cmd_stop  = 3'd4,
        cmd_up    = 3'd5
    } key_cmd_t;

    typedef enum logic [1:0] {mode_run, mode_set_time, mode_set_alarm} mode_t;
    typedef enum logic [1:0] {field_hour, field_minute, field_second} field_t;

    //////////////////////////////////////////////////
    // default timing at 100 MHz
    localparam int DEF_CYCLES_PER_SEC  = 100_000_000;
    localparam int DEF_DEBOUNCE_CYCLES = 2_000_000;   // 20 ms
    localparam int DEF_SCAN_CYCLES     = 10_000;
    localparam int DEF_BLINK_CYCLES    = 50_000_000;  // half a second per phase
    localparam int DEF_BEEP_CYCLES     = 10_000_000;  // 100 ms key beep
    localparam int DEF_TONE_PERIOD     = 151_745;     // mid E

    localparam int ALARM_HALF_PERIOD_SHIFT = 1;  // 50 % duty
    localparam int BEEP_DUTY_SHIFT         = 3;  // 1/8 duty

    localparam hour_t INIT_ALARM_HOUR = 5'd7;
    localparam unit_t INIT_ALARM_MIN  = 6'd1;

    localparam seg_t SEG_DASH = 8'b0000_0010;
    localparam seg_t SEG_TABLE [10] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010, 8'b0110_0110,
        8'b1011_0110, 8'b1011_1110, 8'b1110_0000, 8'b1111_1110, 8'b1111_0110
    };

    // one step up or down with wrap between 0 and max
    function automatic unit_t wrap_step(unit_t value, unit_t max, logic up);
        if (up)
            return (value == max) ? 6'd0 : value + 6'd1;
        else
            return (value == 6'd0) ? max : value - 6'd1;
    endfunction

endpackage

// ==== key_debounce.sv ====
module key_debounce #(
    parameter int DEBOUNCE_CYCLES = clock_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          key,
    output clock_pkg::key_cmd_t key_cmd
);
    import clock_pkg::*;

    typedef logic [$clog2(DEBOUNCE_CYCLES + 1) - 1:0] cnt_t;

    logic [4:0] key_q;       // last sampled key
    cnt_t       stable_cnt;  // cycles the key has stayed unchanged
    key_cmd_t   key_dec;

    always_comb
    begin
        case (key)
            5'b10000: key_dec = cmd_up;
            5'b01000: key_dec = cmd_stop;
            5'b00100: key_dec = cmd_field;
            5'b00010: key_dec = cmd_down;
            5'b00001: key_dec = cmd_mode;
            default:  key_dec = cmd_none;  // idle or several keys
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_q      <= '0;
            stable_cnt <= '0;
            key_cmd    <= cmd_none;
        end
        else
        begin
            key_q   <= key;
            key_cmd <= cmd_none;
            if (key != key_q || key == 5'b0)
                stable_cnt <= '0;  // bounce or release restarts
            else if (stable_cnt != cnt_t'(DEBOUNCE_CYCLES))
            begin
                stable_cnt <= stable_cnt + 1'b1;
                if (stable_cnt == cnt_t'(DEBOUNCE_CYCLES - 1))
                    key_cmd <= key_dec;  // fires once, then saturates
            end
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        key_cmd != cmd_none |=> key_cmd == cmd_none);

endmodule

// ==== mode_control.sv ====
module mode_control (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::key_cmd_t key_cmd,
    output clock_pkg::mode_t    mode,
    output clock_pkg::field_t   field
);
    import clock_pkg::*;

    mode_t mode_nxt;

    always_comb
    begin
        mode_nxt = mode;
        if (key_cmd == cmd_mode)
        begin
            case (mode)
                mode_run:      mode_nxt = mode_set_time;
                mode_set_time: mode_nxt = mode_set_alarm;
                default:       mode_nxt = mode_run;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            mode  <= mode_run;
            field <= field_hour;
        end
        else
        begin
            mode <= mode_nxt;
            if (mode_nxt == mode_run)
                field <= field_hour;  // run never holds a field
            else if (key_cmd == cmd_field)
            begin
                case (field)
                    field_hour:   field <= field_minute;
                    field_minute: field <= field_second;
                    default:      field <= field_hour;
                endcase
            end
        end
    end

    a_run_field: assert property (@(posedge clk) disable iff (!rst)
        mode == mode_run |-> field == field_hour);

endmodule

// ==== time_keeper.sv ====
module time_keeper #(
    parameter int CYCLES_PER_SEC = clock_pkg::DEF_CYCLES_PER_SEC
) (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::mode_t    mode,
    input  clock_pkg::field_t   field,
    input  clock_pkg::key_cmd_t key_cmd,
    output clock_pkg::hour_t    hour,
    output clock_pkg::unit_t    minute,
    output clock_pkg::unit_t    second,
    output logic                time_step
);
    import clock_pkg::*;

    typedef logic [$clog2(CYCLES_PER_SEC) - 1:0] cnt_t;

    cnt_t presc;  // cycles within the current second
    logic adjust;
    logic up;

    assign adjust = (key_cmd == cmd_up) || (key_cmd == cmd_down);
    assign up     = (key_cmd == cmd_up);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            presc     <= '0;
            time_step <= 1'b0;
            hour      <= '0;
            minute    <= '0;
            second    <= '0;
        end
        else if (mode == mode_set_time)
        begin
            presc     <= '0;  // frozen while setting
            time_step <= 1'b0;
            if (adjust)
            begin
                case (field)
                    field_hour:   hour   <= hour_t'(wrap_step({1'b0, hour}, 6'd23, up));
                    field_minute: minute <= wrap_step(minute, 6'd59, up);
                    default:      second <= wrap_step(second, 6'd59, up);
                endcase
            end
        end
        else if (presc == cnt_t'(CYCLES_PER_SEC - 1))
        begin
            presc     <= '0;
            time_step <= 1'b1;
            second    <= wrap_step(second, 6'd59, 1'b1);
            if (second == 6'd59)
            begin
                minute <= wrap_step(minute, 6'd59, 1'b1);
                if (minute == 6'd59)
                    hour <= hour_t'(wrap_step({1'b0, hour}, 6'd23, 1'b1));  // midnight wrap
            end
        end
        else
        begin
            presc     <= presc + 1'b1;
            time_step <= 1'b0;
        end
    end

    a_time_range: assert property (@(posedge clk) disable iff (!rst)
        hour <= 5'd23 && minute <= 6'd59 && second <= 6'd59);

endmodule

// ==== alarm_unit.sv ====
module alarm_unit (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::mode_t    mode,
    input  clock_pkg::field_t   field,
    input  clock_pkg::key_cmd_t key_cmd,
    input  clock_pkg::hour_t    hour,
    input  clock_pkg::unit_t    minute,
    input  clock_pkg::unit_t    second,
    input  logic                time_step,
    input  logic                alarm_en,
    output clock_pkg::hour_t    alarm_hour,
    output clock_pkg::unit_t    alarm_minute,
    output clock_pkg::unit_t    alarm_second,
    output logic                alarm_ring
);
    import clock_pkg::*;

    logic adjust;
    logic up;
    logic match;

    assign adjust = (mode == mode_set_alarm) &&
                    ((key_cmd == cmd_up) || (key_cmd == cmd_down));
    assign up     = (key_cmd == cmd_up);
    assign match  = (hour == alarm_hour) && (minute == alarm_minute) &&
                    (second == alarm_second);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            alarm_hour   <= INIT_ALARM_HOUR;
            alarm_minute <= INIT_ALARM_MIN;
            alarm_second <= '0;
        end
        else if (adjust)
        begin
            case (field)
                field_hour:   alarm_hour   <= hour_t'(wrap_step({1'b0, alarm_hour}, 6'd23, up));
                field_minute: alarm_minute <= wrap_step(alarm_minute, 6'd59, up);
                default:      alarm_second <= wrap_step(alarm_second, 6'd59, up);
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            alarm_ring <= 1'b0;
        else if (key_cmd == cmd_stop)
            alarm_ring <= 1'b0;  // dismiss in any mode
        else if (time_step && alarm_en && match)
            alarm_ring <= 1'b1;  // only on the step into the match
    end

    a_ring_needs_en: assert property (@(posedge clk) disable iff (!rst)
        $rose(alarm_ring) |-> $past(alarm_en));

endmodule

// ==== display_scan.sv ====
module display_scan #(
    parameter int SCAN_CYCLES  = clock_pkg::DEF_SCAN_CYCLES,
    parameter int BLINK_CYCLES = clock_pkg::DEF_BLINK_CYCLES
) (
    input  logic                  clk,
    input  logic                  rst,
    input  clock_pkg::mode_t      mode,
    input  clock_pkg::field_t     field,
    input  clock_pkg::hour_t      hour,
    input  clock_pkg::unit_t      minute,
    input  clock_pkg::unit_t      second,
    input  clock_pkg::hour_t      alarm_hour,
    input  clock_pkg::unit_t      alarm_minute,
    input  clock_pkg::unit_t      alarm_second,
    output clock_pkg::seg_t       seg,
    output clock_pkg::digit_sel_t digit_sel
);
    import clock_pkg::*;

    typedef logic [$clog2(SCAN_CYCLES) - 1:0]  scan_cnt_t;
    typedef logic [$clog2(BLINK_CYCLES) - 1:0] blink_cnt_t;

    scan_cnt_t  scan_cnt;
    blink_cnt_t blink_cnt;
    logic [2:0] scan_idx;   // 0 = leftmost digit
    logic       blink_off;  // selected field dark in this phase
    hour_t      show_h;
    unit_t      show_m;
    unit_t      show_s;
    digit_t     digit;
    logic       in_field;   // position belongs to the selected field
    digit_t     num_q;
    digit_sel_t sel_q;

    //////////////////////////////////////////////////
    // scan and blink timing
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            scan_cnt  <= '0;
            scan_idx  <= '0;
            blink_cnt <= '0;
            blink_off <= 1'b0;
        end
        else
        begin
            if (scan_cnt == scan_cnt_t'(SCAN_CYCLES - 1))
            begin
                scan_cnt <= '0;
                scan_idx <= scan_idx + 1'b1;
            end
            else
                scan_cnt <= scan_cnt + 1'b1;

            if (mode == mode_run)
            begin
                blink_cnt <= '0;
                blink_off <= 1'b0;
            end
            else if (blink_cnt == blink_cnt_t'(BLINK_CYCLES - 1))
            begin
                blink_cnt <= '0;
                blink_off <= ~blink_off;
            end
            else
                blink_cnt <= blink_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // digit value for the current position
    always_comb
    begin
        show_h   = (mode == mode_set_alarm) ? alarm_hour : hour;
        show_m   = (mode == mode_set_alarm) ? alarm_minute : minute;
        show_s   = (mode == mode_set_alarm) ? alarm_second : second;
        digit    = 4'd10;  // dash
        in_field = 1'b0;
        case (scan_idx)
            3'd0: {digit, in_field} = {digit_t'(show_h / 5'd10), field == field_hour};
            3'd1: {digit, in_field} = {digit_t'(show_h % 5'd10), field == field_hour};
            3'd3: {digit, in_field} = {digit_t'(show_m / 6'd10), field == field_minute};
            3'd4: {digit, in_field} = {digit_t'(show_m % 6'd10), field == field_minute};
            3'd6: {digit, in_field} = {digit_t'(show_s / 6'd10), field == field_second};
            3'd7: {digit, in_field} = {digit_t'(show_s % 6'd10), field == field_second};
            default: ;
        endcase
    end

    // stage 1 picks value and enable, stage 2 encodes segments
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            num_q     <= '0;
            sel_q     <= '0;
            seg       <= '0;
            digit_sel <= '0;
        end
        else
        begin
            num_q     <= digit;
            sel_q     <= (blink_off && in_field) ? '0 : digit_sel_t'(8'h80 >> scan_idx);
            seg       <= (num_q > 4'd9) ? SEG_DASH : SEG_TABLE[num_q];
            digit_sel <= sel_q;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(digit_sel));

endmodule

// ==== tone_gen.sv ====
module tone_gen #(
    parameter int BEEP_CYCLES = clock_pkg::DEF_BEEP_CYCLES,
    parameter int TONE_PERIOD = clock_pkg::DEF_TONE_PERIOD
) (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::key_cmd_t key_cmd,
    input  logic                beep_en,
    input  logic                alarm_ring,
    output logic                pwm
);
    import clock_pkg::*;

    typedef logic [$clog2(BEEP_CYCLES) - 1:0] beep_cnt_t;
    typedef logic [$clog2(TONE_PERIOD) - 1:0] tone_cnt_t;

    logic      beep_on;
    beep_cnt_t beep_cnt;  // length of the key beep
    tone_cnt_t tone_cnt;  // position within one tone period

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            beep_on  <= 1'b0;
            beep_cnt <= '0;
            tone_cnt <= '0;
            pwm      <= 1'b0;
        end
        else
        begin
            if (!beep_en)
                beep_on <= 1'b0;
            else if (key_cmd != cmd_none)
            begin
                beep_on  <= 1'b1;  // each press restarts the beep
                beep_cnt <= '0;
            end
            else if (beep_on)
            begin
                if (beep_cnt == beep_cnt_t'(BEEP_CYCLES - 1))
                    beep_on <= 1'b0;
                else
                    beep_cnt <= beep_cnt + 1'b1;
            end

            if (!(beep_on || alarm_ring) || tone_cnt == tone_cnt_t'(TONE_PERIOD - 1))
                tone_cnt <= '0;
            else
                tone_cnt <= tone_cnt + 1'b1;

            if (alarm_ring)  // alarm tone wins over the beep
                pwm <= tone_cnt < tone_cnt_t'(TONE_PERIOD >> ALARM_HALF_PERIOD_SHIFT);
            else if (beep_on && beep_en)
                pwm <= tone_cnt < tone_cnt_t'(TONE_PERIOD >> BEEP_DUTY_SHIFT);
            else
                pwm <= 1'b0;
        end
    end

endmodule

// ==== clock_top.sv ====
module clock_top #(
    parameter int CYCLES_PER_SEC  = clock_pkg::DEF_CYCLES_PER_SEC,
    parameter int DEBOUNCE_CYCLES = clock_pkg::DEF_DEBOUNCE_CYCLES,
    parameter int SCAN_CYCLES     = clock_pkg::DEF_SCAN_CYCLES,
    parameter int BLINK_CYCLES    = clock_pkg::DEF_BLINK_CYCLES,
    parameter int BEEP_CYCLES     = clock_pkg::DEF_BEEP_CYCLES,
    parameter int TONE_PERIOD     = clock_pkg::DEF_TONE_PERIOD
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            key,        // up, stop, field, down, mode
    input  logic                  alarm_en,
    input  logic                  beep_en,
    output clock_pkg::seg_t       seg,
    output clock_pkg::digit_sel_t digit_sel,
    output logic                  alarm_ring,
    output logic                  pwm
);
    import clock_pkg::*;

    key_cmd_t key_cmd;
    mode_t    mode;
    field_t   field;
    hour_t    hour, alarm_hour;
    unit_t    minute, second, alarm_minute, alarm_second;
    logic     time_step;

    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debounce (
        .clk, .rst, .key, .key_cmd);

    mode_control u_mode (.clk, .rst, .key_cmd, .mode, .field);

    time_keeper #(.CYCLES_PER_SEC(CYCLES_PER_SEC)) u_time (
        .clk, .rst, .mode, .field, .key_cmd, .hour, .minute, .second, .time_step);

    alarm_unit u_alarm (
        .clk, .rst, .mode, .field, .key_cmd, .hour, .minute, .second, .time_step,
        .alarm_en, .alarm_hour, .alarm_minute, .alarm_second, .alarm_ring);

    display_scan #(.SCAN_CYCLES(SCAN_CYCLES), .BLINK_CYCLES(BLINK_CYCLES)) u_display (
        .clk, .rst, .mode, .field, .hour, .minute, .second,
        .alarm_hour, .alarm_minute, .alarm_second, .seg, .digit_sel);

    tone_gen #(.BEEP_CYCLES(BEEP_CYCLES), .TONE_PERIOD(TONE_PERIOD)) u_tone (
        .clk, .rst, .key_cmd, .beep_en, .alarm_ring, .pwm);

endmodule

// ==== tb_clock_top.sv ====
module tb_clock_top;
    timeunit 1ns;
    timeprecision 1ps;
    import clock_pkg::*;

    localparam logic [4:0] K_UP    = 5'b10000;
    localparam logic [4:0] K_STOP  = 5'b01000;
    localparam logic [4:0] K_FIELD = 5'b00100;
    localparam logic [4:0] K_DOWN  = 5'b00010;
    localparam logic [4:0] K_MODE  = 5'b00001;

    typedef struct packed {
        logic        do_rst;
        logic [4:0]  key;
        logic        ae;
        logic        be;
        logic [15:0] wait_cyc;
        logic        chk_time;
        hour_t       h;
        unit_t       m;
        unit_t       s;
        unit_t       s_hi;      // upper bound of the accepted seconds
        logic        chk_ring;
        logic        ring;
        logic        chk_pwm;
        logic        pwm_act;
        logic        chk_blink;
        logic        blink;
        logic [2:0]  blink_pos; // tens digit of the selected field
    } step_t;

    logic clk = 1'b0;
    logic rst;
    logic [4:0] key;
    logic alarm_en;
    logic beep_en;
    seg_t seg;
    digit_sel_t digit_sel;
    logic alarm_ring;
    logic pwm;

    step_t tbl [0:255];
    int n_steps = 0;
    int md, fd, th, tm, ts, ah, am, al_s;  // reference model of the clock
    logic cur_ae, cur_be;
    logic [31:0] rng = 32'hea596ab1;
    int errs = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;
    int limit = 0;
    seg_t last_seg [8];
    bit ever_on [8];
    int on_cnt [8];
    bit counting = 0;
    int toggles;
    logic last_pwm;

    clock_top #(.CYCLES_PER_SEC(40), .DEBOUNCE_CYCLES(4), .SCAN_CYCLES(2),
                .BLINK_CYCLES(64), .BEEP_CYCLES(60), .TONE_PERIOD(8)) u_dut (
        .clk, .rst, .key, .alarm_en, .beep_en, .seg, .digit_sel, .alarm_ring, .pwm);

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // display and pwm monitor
    always @(posedge clk)
    begin
        cycles++;
        if (pwm !== last_pwm)
            toggles++;
        last_pwm = pwm;
        for (int p = 0; p < 8; p++)
            if (digit_sel[7 - p])
            begin
                last_seg[p] = seg;
                ever_on[p] = 1'b1;
                if (counting)
                    on_cnt[p]++;
            end
        if (limit != 0 && cycles > limit)
        begin
            $display("timeout: run passed the limit of %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int wrap(input int v, input int max, input bit up);
        if (up)
            return (v == max) ? 0 : v + 1;
        return (v == 0) ? max : v - 1;
    endfunction

    function automatic int seg_digit(input seg_t s);
        int d;
        d = 99;  // no match
        for (int i = 0; i < 10; i++)
            if (SEG_TABLE[i] == s)
                d = i;
        return d;
    endfunction

    //////////////////////////////////////////////////
    // table building with the model
    task automatic reset_model();
        md = 0;
        fd = 0;
        th = 0;
        tm = 0;
        ts = 0;
        ah = 7;
        am = 1;
        al_s = 0;
    endtask

    task automatic push_step(input logic [4:0] k, input int w);
        step_t st;
        bit up;
        up = (k == K_UP);
        if (k == K_MODE)
        begin
            md = (md + 1) % 3;
            if (md == 0)
                fd = 0;
        end
        else if (k == K_FIELD && md != 0)
            fd = (fd + 1) % 3;
        else if ((k == K_UP || k == K_DOWN) && md == 1)
        begin
            if (fd == 0) th = wrap(th, 23, up);
            else if (fd == 1) tm = wrap(tm, 59, up);
            else ts = wrap(ts, 59, up);
        end
        else if ((k == K_UP || k == K_DOWN) && md == 2)
        begin
            if (fd == 0) ah = wrap(ah, 23, up);
            else if (fd == 1) am = wrap(am, 59, up);
            else al_s = wrap(al_s, 59, up);
        end
        st = '0;
        st.key = k;
        st.ae = cur_ae;
        st.be = cur_be;
        st.wait_cyc = w[15:0];
        st.h = hour_t'((md == 2) ? ah : th);
        st.m = unit_t'((md == 2) ? am : tm);
        st.s = unit_t'((md == 2) ? al_s : ts);
        st.s_hi = st.s;
        st.blink_pos = 3'(fd * 3);
        tbl[n_steps] = st;
        n_steps++;
    endtask

    task automatic push_reset();
        reset_model();
        push_step(5'b0, 0);
        tbl[n_steps - 1].do_rst = 1'b1;
    endtask

    task automatic expect_flags(input bit t, input int ring, input int pact, input int blink);
        tbl[n_steps - 1].chk_time = t;
        tbl[n_steps - 1].chk_ring = (ring >= 0);
        tbl[n_steps - 1].ring = (ring == 1);
        tbl[n_steps - 1].chk_pwm = (pact >= 0);
        tbl[n_steps - 1].pwm_act = (pact == 1);
        tbl[n_steps - 1].chk_blink = (blink >= 0);
        tbl[n_steps - 1].blink = (blink == 1);
    endtask

    task automatic random_presses(input int n);
        for (int i = 0; i < n; i++)
        begin
            rng = xorshift(rng);
            push_step(rng[0] ? K_UP : K_DOWN, 160);
            expect_flags(1, -1, -1, -1);
        end
    endtask

    task automatic set_0700_58();
        push_step(K_MODE, 4);
        while (th != 7)
            push_step(K_UP, 4);
        push_step(K_FIELD, 4);
        push_step(K_FIELD, 4);
        push_step(K_DOWN, 4);
        push_step(K_DOWN, 4);
        push_step(5'b0, 160);
        expect_flags(1, -1, -1, -1);
    endtask

    //////////////////////////////////////////////////
    // checks
    task automatic check_time(input hour_t eh, input unit_t em, input unit_t es,
                              input unit_t es_hi, input hour_t gh, input unit_t gm,
                              input unit_t gs);
        if (gh !== eh)
        begin
            $display("ERROR %0t display hour expected %0d got %0d", $time, eh, gh);
            errs++;
        end
        if (gm !== em)
        begin
            $display("ERROR %0t display minute expected %0d got %0d", $time, em, gm);
            errs++;
        end
        if (gs < es || gs > es_hi)
        begin
            $display("ERROR %0t display second expected %0d..%0d got %0d",
                     $time, es, es_hi, gs);
            errs++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t got);
        if (got !== exp)
        begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
            errs++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic run_step(input step_t st);
        int gd [8];
        int diff;
        bit sel;
        if (st.do_rst)
        begin
            rst = 1'b0;
            repeat (8) tick();
            rst = 1'b1;
        end
        alarm_en = st.ae;
        beep_en = st.be;
        toggles = 0;
        if (st.key != 5'b0)
        begin
            key = st.key;
            repeat (10) tick();
            key = 5'b0;
            repeat (10) tick();
        end
        for (int p = 0; p < 8; p++)
            on_cnt[p] = 0;
        counting = 1;
        repeat (st.wait_cyc) tick();
        counting = 0;
        if (st.chk_time)
        begin
            for (int p = 0; p < 8; p++)
            begin
                gd[p] = seg_digit(last_seg[p]);
                if (p != 2 && p != 5 && (!ever_on[p] || gd[p] == 99))
                begin
                    $display("display digit %0d shows no readable number", p);
                    errs++;
                end
            end
            check_seg("seg of dash 2", SEG_DASH, last_seg[2]);
            check_seg("seg of dash 5", SEG_DASH, last_seg[5]);
            check_time(st.h, st.m, st.s, st.s_hi, hour_t'(gd[0] * 10 + gd[1]),
                       unit_t'(gd[3] * 10 + gd[4]), unit_t'(gd[6] * 10 + gd[7]));
        end
        if (st.chk_ring)
            check_flag("alarm_ring", st.ring, alarm_ring);
        if (st.chk_pwm)
            check_flag("pwm activity", st.pwm_act, toggles > 0);
        if (st.chk_blink)
            for (int p = 0; p < 8; p++)
            begin
                sel = (p == st.blink_pos) || (p == st.blink_pos + 1);
                diff = on_cnt[p] - on_cnt[2];
                if (st.blink && sel)
                begin
                    if (!(on_cnt[p] > 0 && on_cnt[p] + 8 < on_cnt[2]))
                    begin
                        $display("digit %0d did not blink (on %0d cycles)", p, on_cnt[p]);
                        errs++;
                    end
                end
                else if (diff > 2 || diff < -2)
                begin
                    $display("digit %0d enabled %0d cycles, dash %0d", p, on_cnt[p], on_cnt[2]);
                    errs++;
                end
            end
    endtask

    initial
    begin
        int e0;
        int total;
        rst = 1'b0;
        key = 5'b0;
        alarm_en = 1'b0;
        beep_en = 1'b0;
        last_pwm = 1'b0;
        cur_ae = 1'b0;
        cur_be = 1'b0;
        reset_model();

        // frozen 00-00-00 in set_time with the hour blinking
        push_step(K_MODE, 160);
        expect_flags(1, -1, -1, -1);
        push_step(5'b0, 200);
        expect_flags(1, -1, -1, -1);
        push_step(5'b0, 300);
        expect_flags(1, -1, -1, 1);
        // field adjustment with wrap
        push_step(K_DOWN, 160);
        expect_flags(1, -1, -1, -1);
        push_step(K_UP, 160);
        expect_flags(1, -1, -1, -1);
        rng = xorshift(rng);
        random_presses(2 + rng % 4);
        for (int f = 0; f < 2; f++)
        begin
            push_step(K_FIELD, 300);
            expect_flags(1, -1, -1, 1);
            push_step(K_DOWN, 160);
            expect_flags(1, -1, -1, -1);
            push_step(K_UP, 160);
            expect_flags(1, -1, -1, -1);
            rng = xorshift(rng);
            random_presses(2 + rng % 4);
        end
        // 23:59:58 then about five seconds of running
        push_step(K_FIELD, 4);
        while (th != 23)
            push_step((th < 12) ? K_DOWN : K_UP, 4);
        push_step(K_FIELD, 4);
        while (tm != 59)
            push_step((tm < 30) ? K_DOWN : K_UP, 4);
        push_step(K_FIELD, 4);
        while (ts != 58)
            push_step((ts < 29 || ts == 59) ? K_DOWN : K_UP, 4);
        push_step(5'b0, 160);
        expect_flags(1, -1, -1, -1);
        push_step(K_MODE, 0);
        push_step(K_MODE, 165);
        expect_flags(0, -1, -1, 0);
        push_step(K_MODE, 160);
        expect_flags(1, -1, -1, -1);
        tbl[n_steps - 1].h = 5'd0;
        tbl[n_steps - 1].m = 6'd0;
        tbl[n_steps - 1].s = 6'd2;
        tbl[n_steps - 1].s_hi = 6'd4;
        // alarm edit with alarm_en low never rings
        push_reset();
        set_0700_58();
        push_step(K_MODE, 160);
        expect_flags(1, 0, -1, -1);
        push_step(K_UP, 160);
        expect_flags(1, 0, -1, -1);
        push_step(K_DOWN, 160);
        expect_flags(1, 0, -1, -1);
        push_step(5'b0, 100);
        expect_flags(0, 0, -1, -1);
        // alarm with alarm_en high until stop
        cur_ae = 1'b1;
        push_reset();
        set_0700_58();
        push_step(K_MODE, 0);
        push_step(K_MODE, 120);
        expect_flags(0, 1, 1, 0);
        push_step(K_STOP, 20);
        expect_flags(0, 0, -1, -1);
        // key beep
        cur_ae = 1'b0;
        cur_be = 1'b1;
        push_step(K_STOP, 100);
        expect_flags(0, 0, 1, -1);
        push_step(5'b0, 60);
        expect_flags(0, -1, 0, -1);
        cur_be = 1'b0;
        push_step(K_STOP, 100);
        expect_flags(0, -1, 0, -1);

        total = 8;
        for (int i = 0; i < n_steps; i++)
            total += (tbl[i].do_rst ? 8 : 0) + ((tbl[i].key != 0) ? 20 : 0) + tbl[i].wait_cyc;
        limit = total * 3 / 2;

        repeat (8) tick();
        rst = 1'b1;
        for (int i = 0; i < n_steps; i++)
        begin
            e0 = errs;
            run_step(tbl[i]);
            if (errs == e0)
            begin
                pass_cnt++;
                $display("step %0d key %b: ok", i, tbl[i].key);
            end
            else
            begin
                fail_cnt++;
                $display("step %0d key %b: %0d errors", i, tbl[i].key, errs - e0);
            end
        end
        $display("steps passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
clock_pkg.sv
key_debounce.sv
mode_control.sv
time_keeper.sv
alarm_unit.sv
display_scan.sv
tone_gen.sv
clock_top.sv
tb_clock_top.sv
